// ==== rvc_pkg.sv ====
// shared RV32C types, opcode patterns and helpers used by the compressed front end blocks
package rvc_pkg;

  typedef logic [31:0] instr_t;     // one base instruction word
  typedef logic [15:0] cinstr_t;    // one compressed halfword
  typedef logic [4:0]  reg_addr_t;  // x0..x31
  typedef logic [2:0]  creg_addr_t; // x8..x15 encoded

  localparam logic [1:0] OPCODE_NC = 2'b11; // low bits of a full-size instruction

  // compressed patterns, ordered so that the special cases can be matched first
  localparam cinstr_t C_ZERO     = 16'b000_0_00000_00000_00;
  localparam cinstr_t C_NOP      = 16'b000_0_00000_00000_01;
  localparam cinstr_t C_EBREAK   = 16'b100_1_00000_00000_10;
  localparam cinstr_t C_LWSP     = 16'b010_?_?????_?????_10;
  localparam cinstr_t C_SWSP     = 16'b110_?_?????_?????_10;
  localparam cinstr_t C_LW       = 16'b010_???_???_??_???_00;
  localparam cinstr_t C_SW       = 16'b110_???_???_??_???_00;
  localparam cinstr_t C_J        = 16'b101_?_?????_?????_01;
  localparam cinstr_t C_JAL      = 16'b001_?_?????_?????_01;
  localparam cinstr_t C_JR       = 16'b100_0_?????_00000_10;
  localparam cinstr_t C_JALR     = 16'b100_1_?????_00000_10;
  localparam cinstr_t C_BEQZ     = 16'b110_???_???_?????_01;
  localparam cinstr_t C_BNEZ     = 16'b111_???_???_?????_01;
  localparam cinstr_t C_ADDI     = 16'b000_?_?????_?????_01;
  localparam cinstr_t C_ADDI16SP = 16'b011_?_00010_?????_01;
  localparam cinstr_t C_ADDI4SPN = 16'b000_????????_???_00;
  localparam cinstr_t C_SLLI     = 16'b000_?_?????_?????_10;
  localparam cinstr_t C_SRLI     = 16'b100_?_00_???_?????_01;
  localparam cinstr_t C_SRAI     = 16'b100_?_01_???_?????_01;
  localparam cinstr_t C_ANDI     = 16'b100_?_10_???_?????_01;
  localparam cinstr_t C_LI       = 16'b010_?_?????_?????_01;
  localparam cinstr_t C_LUI      = 16'b011_?_?????_?????_01;
  localparam cinstr_t C_MV       = 16'b100_0_?????_?????_10;
  localparam cinstr_t C_ADD      = 16'b100_1_?????_?????_10;
  localparam cinstr_t C_SUB      = 16'b100_0_11_???_00_???_01;
  localparam cinstr_t C_XOR      = 16'b100_0_11_???_01_???_01;
  localparam cinstr_t C_OR       = 16'b100_0_11_???_10_???_01;
  localparam cinstr_t C_AND      = 16'b100_0_11_???_11_???_01;

  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;

  localparam instr_t INSTR_NOP  = 32'h0000_0013; // addi x0, x0, 0
  localparam instr_t INSTR_ZERO = 32'h0000_0000;

  // source of the word handed to the decode stage
  typedef enum logic [2:0] {
    sel_joint,     // fetched word as is
    sel_lower,     // expand low half
    sel_upper,     // expand high half
    sel_split,     // current low half over saved high half
    sel_upper_old, // expand saved high half
    sel_none       // bubble
  } align_sel_e;

  // compressed register fields only reach x8..x15
  function automatic reg_addr_t expand_creg(input creg_addr_t i_creg);
    return {2'b01, i_creg};
  endfunction

endpackage

// ==== rvc_align_if.sv ====
// selector and compression flags exchanged between the alignment FSM and the fetch buffer
`timescale 1ns/1ps

interface rvc_align_if;

  rvc_pkg::align_sel_e sel;  // which source feeds o_instr this cycle
  logic lower_comp;          // low half of i_instr is compressed
  logic upper_comp;          // high half compressed, only valid behind a compressed low half
  logic upper_comp_old;      // high half of the saved word is compressed

  modport fsm_mp (
    output sel,
    input  lower_comp,
    input  upper_comp,
    input  upper_comp_old
  );

  modport buf_mp (
    input  sel,
    output lower_comp,
    output upper_comp,
    output upper_comp_old
  );

endinterface

// ==== rvc_align_fsm.sv ====
// alignment FSM that tracks halfword position and drives the selector and fetch-control strobes
`timescale 1ns/1ps

module rvc_align_fsm (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_update_comp,   // pipeline advance strobe
  input  logic               i_bypass_decomp,
  input  logic               i_branch_taken,
  input  logic               i_half_pc_addr,  // pc not word aligned
  input  logic               i_half_npc_addr, // npc not word aligned
  rvc_align_if.fsm_mp        align,
  output logic               o_offset_pc,
  output logic               o_refetch,
  output logic               o_freeze_pc,
  output logic               o_compressed
);

  typedef enum logic [2:0] {
    st_full_joint,     // aligned 32-bit word
    st_full_split,     // 32-bit word across two fetches
    st_half_lower,     // compressed low half
    st_half_upper,     // compressed high half of the current word
    st_half_upper_old, // compressed high half of the saved word
    st_fetch_next      // landed mid-word, wait for the next fetch
  } state_e;

  state_e state_q;     // state of the last strobed cycle
  state_e state_d;     // state for this cycle, drives the outputs
  logic   branch_q;
  logic   half_pc_q;
  logic   half_npc_q;
  logic   redirect_half;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q    <= st_full_joint;
      branch_q   <= 1'b0;
      half_pc_q  <= 1'b0;
      half_npc_q <= 1'b0;
    end else if (i_update_comp) begin
      state_q    <= state_d;
      branch_q   <= i_branch_taken;
      half_pc_q  <= i_half_pc_addr;
      half_npc_q <= i_half_npc_addr;
    end
  end

  always_comb begin
    case (state_q)
      st_full_joint: begin
        if (branch_q && half_pc_q) state_d = st_fetch_next;
        else if (align.lower_comp) state_d = st_half_lower;
        else                       state_d = st_full_joint;
      end
      st_half_lower: begin
        if (branch_q && !half_pc_q) begin  // branch back onto a word boundary
          state_d = align.lower_comp ? st_half_lower : st_full_joint;
        end else begin
          state_d = align.upper_comp_old ? st_half_upper : st_full_split;
        end
      end
      st_half_upper, st_half_upper_old: begin
        if (branch_q && half_pc_q) begin
          state_d = align.upper_comp ? st_half_upper : st_full_split;
        end else begin
          state_d = align.lower_comp ? st_half_lower : st_full_joint;
        end
      end
      st_full_split: begin
        if (branch_q && !half_npc_q) begin
          state_d = align.lower_comp ? st_half_lower : st_full_joint;
        end else begin
          state_d = align.upper_comp_old ? st_half_upper : st_full_split;
        end
      end
      st_fetch_next: begin
        state_d = align.upper_comp_old ? st_half_upper_old : st_full_split;
      end
      default: state_d = st_full_joint;
    endcase
  end

  assign redirect_half = i_branch_taken & (i_half_pc_addr | half_npc_q);

  always_comb begin
    align.sel    = rvc_pkg::sel_none;
    o_compressed = 1'b0;
    o_offset_pc  = 1'b0;
    o_refetch    = 1'b0;
    o_freeze_pc  = 1'b0;
    if (i_bypass_decomp) begin
      align.sel = rvc_pkg::sel_joint; // raw word, no strobes
    end else begin
      case (state_d)
        st_full_joint: begin
          align.sel   = rvc_pkg::sel_joint;
          o_refetch   = redirect_half;
          o_freeze_pc = redirect_half;
        end
        st_half_lower: begin
          align.sel    = rvc_pkg::sel_lower;
          o_compressed = 1'b1;
          o_offset_pc  = !align.upper_comp && i_half_npc_addr;
        end
        st_half_upper: begin
          align.sel    = rvc_pkg::sel_upper;
          o_compressed = 1'b1;
        end
        st_full_split: begin
          align.sel   = rvc_pkg::sel_split;
          o_offset_pc = !align.upper_comp && i_half_npc_addr;
        end
        st_half_upper_old: begin
          align.sel    = rvc_pkg::sel_upper_old;
          o_compressed = 1'b1;
        end
        st_fetch_next: begin
          o_offset_pc = 1'b1; // bubble while the next word arrives
          o_freeze_pc = 1'b1;
        end
        default: align.sel = rvc_pkg::sel_none;
      endcase
    end
  end

  a_state_legal: assert property (@(posedge i_clk) disable iff (i_rst)
    state_q inside {st_full_joint, st_full_split, st_half_lower,
                    st_half_upper, st_half_upper_old, st_fetch_next});

  a_refetch_freeze: assert property (@(posedge i_clk) disable iff (i_rst)
    o_refetch |-> o_freeze_pc);

endmodule

// ==== rvc_fetch_buffer.sv ====
// saved fetch word, compression detection, halfword pick and output mux of the RVC front end
`timescale 1ns/1ps

module rvc_fetch_buffer (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_update_comp,
  input  rvc_pkg::instr_t  i_instr,     // word from fetch
  input  rvc_pkg::instr_t  i_expanded,  // expander result for o_half
  rvc_align_if.buf_mp      align,
  output rvc_pkg::cinstr_t o_half,      // halfword to expand
  output rvc_pkg::instr_t  o_instr
);

  rvc_pkg::instr_t saved_q; // previous fetch word

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      saved_q <= rvc_pkg::INSTR_ZERO;
    end else if (i_update_comp) begin
      saved_q <= i_instr;
    end
  end

  // a high half only starts an instruction when the low half was a compressed one
  always_comb begin
    align.lower_comp     = (i_instr[1:0] != rvc_pkg::OPCODE_NC);
    align.upper_comp     = (i_instr[17:16] != rvc_pkg::OPCODE_NC) && align.lower_comp;
    align.upper_comp_old = (saved_q[17:16] != rvc_pkg::OPCODE_NC);
  end

  always_comb begin
    case (align.sel)
      rvc_pkg::sel_lower:     o_half = i_instr[15:0];
      rvc_pkg::sel_upper:     o_half = i_instr[31:16];
      rvc_pkg::sel_upper_old: o_half = saved_q[31:16];
      default:                o_half = '0; // nothing to expand
    endcase
  end

  always_comb begin
    case (align.sel)
      rvc_pkg::sel_joint: o_instr = i_instr;
      rvc_pkg::sel_split: o_instr = {i_instr[15:0], saved_q[31:16]}; // join halves
      rvc_pkg::sel_none:  o_instr = rvc_pkg::INSTR_ZERO;
      default:            o_instr = i_expanded;
    endcase
  end

  a_none_is_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    (align.sel == rvc_pkg::sel_none) |-> (o_instr == rvc_pkg::INSTR_ZERO));

endmodule

// ==== rvc_expander.sv ====
// combinational expansion of one RV32C halfword into its equivalent RV32I instruction
`timescale 1ns/1ps

module rvc_expander (
  input  rvc_pkg::cinstr_t i_half,
  output rvc_pkg::instr_t  o_instr
);

  rvc_pkg::reg_addr_t rd_full;   // rd/rs1 at [11:7]
  rvc_pkg::reg_addr_t rs2_full;  // rs2 at [6:2]
  rvc_pkg::reg_addr_t rs1_p;     // rs1'/rd' at [9:7]
  rvc_pkg::reg_addr_t rs2_p;     // rs2'/rd' at [4:2]
  logic [11:0]        imm6_sext; // ci-format signed imm
  logic [11:0]        lw_off;    // c.lw / c.sw byte offset
  logic [11:0]        lwsp_off;
  logic [11:0]        swsp_off;
  logic [11:0]        sp16_imm;  // c.addi16sp
  logic [11:0]        spn_imm;   // c.addi4spn
  logic [11:1]        j_off;
  logic [8:1]         b_off;

  assign rd_full   = i_half[11:7];
  assign rs2_full  = i_half[6:2];
  assign rs1_p     = rvc_pkg::expand_creg(i_half[9:7]);
  assign rs2_p     = rvc_pkg::expand_creg(i_half[4:2]);
  assign imm6_sext = {{6{i_half[12]}}, i_half[12], i_half[6:2]};

  assign lw_off   = {5'b0, i_half[5], i_half[12:10], i_half[6], 2'b0};
  assign lwsp_off = {4'b0, i_half[3:2], i_half[12], i_half[6:4], 2'b0};
  assign swsp_off = {4'b0, i_half[8:7], i_half[12:9], 2'b0};
  assign sp16_imm = {{3{i_half[12]}}, i_half[4:3], i_half[5], i_half[2], i_half[6], 4'b0};
  assign spn_imm  = {2'b0, i_half[10:7], i_half[12:11], i_half[5], i_half[6], 2'b0};

  // offset bits scattered over [12:2]
  assign j_off = {i_half[12], i_half[8], i_half[10:9], i_half[6],
                  i_half[7], i_half[2], i_half[11], i_half[5:3]};
  assign b_off = {i_half[12], i_half[6:5], i_half[2], i_half[11:10], i_half[4:3]};

  // first match wins, so special encodings sit above their general patterns
  always_comb begin
    casez (i_half)
      rvc_pkg::C_ZERO:   o_instr = rvc_pkg::INSTR_ZERO; // illegal all-zero half
      rvc_pkg::C_NOP:    o_instr = rvc_pkg::INSTR_NOP;
      rvc_pkg::C_EBREAK: o_instr = 32'h0010_0073;       // ebreak

      rvc_pkg::C_LWSP: begin
        o_instr = {lwsp_off, 5'd2, 3'b010, rd_full, rvc_pkg::OP_LOAD};
      end
      rvc_pkg::C_SWSP: begin
        o_instr = {swsp_off[11:5], rs2_full, 5'd2, 3'b010, swsp_off[4:0], rvc_pkg::OP_STORE};
      end
      rvc_pkg::C_LW: begin
        o_instr = {lw_off, rs1_p, 3'b010, rs2_p, rvc_pkg::OP_LOAD};
      end
      rvc_pkg::C_SW: begin
        o_instr = {lw_off[11:5], rs2_p, rs1_p, 3'b010, lw_off[4:0], rvc_pkg::OP_STORE};
      end

      rvc_pkg::C_J: begin   // jal x0
        o_instr = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                   5'd0, rvc_pkg::OP_JAL};
      end
      rvc_pkg::C_JAL: begin // jal x1
        o_instr = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                   5'd1, rvc_pkg::OP_JAL};
      end
      rvc_pkg::C_JR:   o_instr = {12'b0, rd_full, 3'b000, 5'd0, rvc_pkg::OP_JALR};
      rvc_pkg::C_JALR: o_instr = {12'b0, rd_full, 3'b000, 5'd1, rvc_pkg::OP_JALR};

      rvc_pkg::C_BEQZ: begin
        o_instr = {b_off[8], {2{b_off[8]}}, b_off[8:5], 5'd0, rs1_p, 3'b000,
                   b_off[4:1], b_off[8], rvc_pkg::OP_BRANCH};
      end
      rvc_pkg::C_BNEZ: begin
        o_instr = {b_off[8], {2{b_off[8]}}, b_off[8:5], 5'd0, rs1_p, 3'b001,
                   b_off[4:1], b_off[8], rvc_pkg::OP_BRANCH};
      end

      rvc_pkg::C_ADDI: begin
        o_instr = {imm6_sext, rd_full, 3'b000, rd_full, rvc_pkg::OP_IMM};
      end
      rvc_pkg::C_ADDI16SP: begin
        o_instr = {sp16_imm, 5'd2, 3'b000, 5'd2, rvc_pkg::OP_IMM};
      end
      rvc_pkg::C_ADDI4SPN: begin
        o_instr = {spn_imm, 5'd2, 3'b000, rs2_p, rvc_pkg::OP_IMM};
      end
      rvc_pkg::C_SLLI: begin
        o_instr = {6'b0, i_half[12], rs2_full, rd_full, 3'b001, rd_full, rvc_pkg::OP_IMM};
      end
      rvc_pkg::C_SRLI: begin
        o_instr = {6'b0, i_half[12], rs2_full, rs1_p, 3'b101, rs1_p, rvc_pkg::OP_IMM};
      end
      rvc_pkg::C_SRAI: begin // funct7 0100000
        o_instr = {6'b010000, i_half[12], rs2_full, rs1_p, 3'b101, rs1_p, rvc_pkg::OP_IMM};
      end
      rvc_pkg::C_ANDI: begin
        o_instr = {imm6_sext, rs1_p, 3'b111, rs1_p, rvc_pkg::OP_IMM};
      end

      rvc_pkg::C_LI: begin  // addi rd, x0, imm
        o_instr = {imm6_sext, 5'd0, 3'b000, rd_full, rvc_pkg::OP_IMM};
      end
      rvc_pkg::C_LUI: begin
        o_instr = {{14{i_half[12]}}, i_half[12], i_half[6:2], rd_full, rvc_pkg::OP_LUI};
      end

      rvc_pkg::C_MV: begin  // add rd, x0, rs2
        o_instr = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, rvc_pkg::OP_OP};
      end
      rvc_pkg::C_ADD: begin
        o_instr = {7'b0, rs2_full, rd_full, 3'b000, rd_full, rvc_pkg::OP_OP};
      end
      rvc_pkg::C_SUB: begin
        o_instr = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p, rvc_pkg::OP_OP};
      end
      rvc_pkg::C_XOR: o_instr = {7'b0, rs2_p, rs1_p, 3'b100, rs1_p, rvc_pkg::OP_OP};
      rvc_pkg::C_OR:  o_instr = {7'b0, rs2_p, rs1_p, 3'b110, rs1_p, rvc_pkg::OP_OP};
      rvc_pkg::C_AND: o_instr = {7'b0, rs2_p, rs1_p, 3'b111, rs1_p, rvc_pkg::OP_OP};

      default: o_instr = rvc_pkg::INSTR_ZERO; // float forms and reserved codes
    endcase
  end

endmodule

// ==== rvc_decompressor.sv ====
// top level of the RV32C front end, joins alignment FSM, fetch buffer and expander
`timescale 1ns/1ps

module rvc_decompressor (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_update_comp,
  input  logic            i_bypass_decomp,
  input  logic            i_branch_taken,
  input  logic            i_half_pc_addr,
  input  logic            i_half_npc_addr,
  input  rvc_pkg::instr_t i_instr,
  output rvc_pkg::instr_t o_instr,
  output logic            o_compressed,
  output logic            o_offset_pc,
  output logic            o_refetch,
  output logic            o_freeze_pc
);

  rvc_pkg::cinstr_t half;     // picked halfword
  rvc_pkg::instr_t  expanded; // its base form

  rvc_align_if align_i ();

  rvc_align_fsm fsm_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_update_comp   (i_update_comp),
    .i_bypass_decomp (i_bypass_decomp),
    .i_branch_taken  (i_branch_taken),
    .i_half_pc_addr  (i_half_pc_addr),
    .i_half_npc_addr (i_half_npc_addr),
    .align           (align_i.fsm_mp),
    .o_offset_pc     (o_offset_pc),
    .o_refetch       (o_refetch),
    .o_freeze_pc     (o_freeze_pc),
    .o_compressed    (o_compressed)
  );

  rvc_fetch_buffer buf_i (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_update_comp (i_update_comp),
    .i_instr       (i_instr),
    .i_expanded    (expanded),
    .align         (align_i.buf_mp),
    .o_half        (half),
    .o_instr       (o_instr)
  );

  rvc_expander exp_i (
    .i_half  (half),
    .o_instr (expanded)
  );

endmodule

// ==== tb_rvc_decompressor.sv ====
// directed testbench for the RV32C decompressor, compiled from the file list as simulation top
`timescale 1ns/1ps

module tb_rvc_decompressor;

  localparam int              RESET_TIMEOUT = 20;            // cycles
  localparam rvc_pkg::instr_t ADDI_X1_5     = 32'h0050_0093; // addi x1, x0, 5

  logic            i_clk;
  logic            i_rst;
  logic            i_update_comp;
  logic            i_bypass_decomp;
  logic            i_branch_taken;
  logic            i_half_pc_addr;
  logic            i_half_npc_addr;
  rvc_pkg::instr_t i_instr;
  rvc_pkg::instr_t o_instr;
  logic            o_compressed;
  logic            o_offset_pc;
  logic            o_refetch;
  logic            o_freeze_pc;

  rvc_decompressor dut_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_update_comp   (i_update_comp),
    .i_bypass_decomp (i_bypass_decomp),
    .i_branch_taken  (i_branch_taken),
    .i_half_pc_addr  (i_half_pc_addr),
    .i_half_npc_addr (i_half_npc_addr),
    .i_instr         (i_instr),
    .o_instr         (o_instr),
    .o_compressed    (o_compressed),
    .o_offset_pc     (o_offset_pc),
    .o_refetch       (o_refetch),
    .o_freeze_pc     (o_freeze_pc)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk; // 8 ns period
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input rvc_pkg::instr_t expected);
    assert (o_instr === expected) else begin
      stop_on_error($sformatf("FAILED %s o_instr expected %h actual %h",
                              name, expected, o_instr));
    end
  endtask

  // flags are {compressed, offset_pc, refetch, freeze_pc}
  task automatic check_flags(input string name, input logic [3:0] expected);
    logic [3:0] actual;
    actual = {o_compressed, o_offset_pc, o_refetch, o_freeze_pc};
    assert (actual === expected) else begin
      stop_on_error($sformatf("FAILED %s flags expected %b actual %b", name, expected, actual));
    end
  endtask

  // starts 1 ns after an edge, checks mid-cycle, returns 1 ns after the next edge
  task automatic run_cycle(input string name, input rvc_pkg::instr_t instr, input logic br,
                           input logic hpc, input logic byp, input rvc_pkg::instr_t exp_instr,
                           input logic [3:0] exp_flags);
    i_instr         = instr;
    i_update_comp   = 1'b1;
    i_branch_taken  = br;
    i_half_pc_addr  = hpc;
    i_half_npc_addr = 1'b0;
    i_bypass_decomp = byp;
    #3;
    check_word(name, exp_instr);
    check_flags(name, exp_flags);
    @(posedge i_clk);
    #1;
  endtask

  task automatic reset_dut();
    int cycles;
    cycles          = 0;
    i_rst           = 1'b1;
    i_update_comp   = 1'b0;
    i_branch_taken  = 1'b0;
    i_half_pc_addr  = 1'b0;
    i_bypass_decomp = 1'b0;
    i_instr         = ADDI_X1_5;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    #3;
    while (!(o_instr === i_instr && o_compressed === 1'b0 && o_freeze_pc === 1'b0)) begin
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        stop_on_error("timed out waiting for the DUT to come out of reset in the joint state");
      end else begin
        @(posedge i_clk);
        #4;
      end
    end
    @(posedge i_clk);
    #1;
  endtask

  task automatic pass_joint_word();
    reset_dut();
    run_cycle("joint_word", ADDI_X1_5, 1'b0, 1'b0, 1'b0, ADDI_X1_5, 4'b0000);
  endtask

  // c.li x5, 3 below c.add x5, x6
  task automatic expand_compressed_pair();
    reset_dut();
    run_cycle("pair_lower", 32'h929A_428D, 1'b0, 1'b0, 1'b0, 32'h0030_0293, 4'b1000);
    run_cycle("pair_upper", 32'h929A_428D, 1'b0, 1'b0, 1'b0, 32'h0062_82B3, 4'b1000);
  endtask

  // c.mv x10, x11 then lw x12, 8(x13) across two words
  task automatic join_split_word();
    reset_dut();
    run_cycle("split_mv", 32'hA603_852E, 1'b0, 1'b0, 1'b0, 32'h00B0_0533, 4'b1000);
    run_cycle("split_lw", 32'h0001_0086, 1'b0, 1'b0, 1'b0, 32'h0086_A603, 4'b0000);
  endtask

  task automatic redirect_to_half();
    reset_dut();
    run_cycle("branch_redirect", ADDI_X1_5, 1'b1, 1'b1, 1'b0, ADDI_X1_5, 4'b0011);
    run_cycle("branch_bubble", 32'h428D_0001, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 4'b0101);
    run_cycle("branch_upper_old", ADDI_X1_5, 1'b0, 1'b0, 1'b0, 32'h0030_0293, 4'b1000);
  endtask

  // low half expands first, then the c.nop above it
  task automatic check_lower_expansion(input string name, input rvc_pkg::cinstr_t half,
                                       input rvc_pkg::instr_t expected);
    run_cycle(name, {16'h0001, half}, 1'b0, 1'b0, 1'b0, expected, 4'b1000);
    run_cycle({name, "_upper_nop"}, {16'h0001, half}, 1'b0, 1'b0, 1'b0,
              32'h0000_0013, 4'b1000);
  endtask

  task automatic sweep_expansions();
    reset_dut();
    check_lower_expansion("c_lw", 16'h416C, 32'h0445_2583);       // lw x11, 68(x10)
    check_lower_expansion("c_sw", 16'hC16C, 32'h04B5_2223);       // sw x11, 68(x10)
    check_lower_expansion("c_j", 16'hBFF5, 32'hFFDF_F06F);        // jal x0, -4
    check_lower_expansion("c_beqz", 16'hC481, 32'h0004_8463);     // beq x9, x0, 8
    check_lower_expansion("c_addi16sp", 16'h7139, 32'hFC01_0113); // addi sp, sp, -64
    check_lower_expansion("c_srai", 16'h850D, 32'h4035_5513);     // srai x10, x10, 3
    check_lower_expansion("c_sub", 16'h8C05, 32'h4094_0433);      // sub x8, x8, x9
    check_lower_expansion("c_lui", 16'h72FD, 32'hFFFF_F2B7);      // lui x5, 0xfffff
    check_lower_expansion("c_flw", 16'h616C, 32'h0000_0000);      // unsupported
  endtask

  task automatic bypass_pair();
    reset_dut();
    run_cycle("bypass_pair", 32'h929A_428D, 1'b1, 1'b1, 1'b1, 32'h929A_428D, 4'b0000);
  endtask

  initial begin
    i_rst           = 1'b1;
    i_update_comp   = 1'b0;
    i_bypass_decomp = 1'b0;
    i_branch_taken  = 1'b0;
    i_half_pc_addr  = 1'b0;
    i_half_npc_addr = 1'b0;
    i_instr         = '0;
    pass_joint_word();
    expand_compressed_pair();
    join_split_word();
    redirect_to_half();
    sweep_expansions();
    bypass_pair();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
rvc_pkg.sv
rvc_align_if.sv
rvc_align_fsm.sv
rvc_fetch_buffer.sv
rvc_expander.sv
rvc_decompressor.sv
tb_rvc_decompressor.sv
